// ==== tests/eth_stim.txt ====
# columns: name own_mac dest_mac nbytes(dec) expect_accept ack
# expect_accept 0 means rx state must stay as before; ack 0 leaves the frame pending
empty_payload   0a1b2c3d4e5f 0a1b2c3d4e5f 0   1 1
one_byte        0a1b2c3d4e5f 0a1b2c3d4e5f 1   1 1
dest_mismatch   0a1b2c3d4e5f 0a1b2c3d4e50 10  0 1
mid_frame       021100aabbcc 021100aabbcc 60  1 1
first_pending   5e0000123456 5e0000123456 16  1 0
dropped_frame   5e0000123456 5e0000123456 20  0 1
max_frame       ffeeddccbbaa ffeeddccbbaa 122 1 1
mismatch_high   ffeeddccbbaa 7feeddccbbaa 5   0 1
long_frame      123456789abc 123456789abc 100 1 1

// ==== filelist.f ====
+incdir+common
common/eth_reg_pkg.sv
common/eth_frame_pkg.sv
hdl/eth_buffer.sv
hdl/eth_regs.sv
eth_tx/eth_tx.sv
eth_rx/eth_rx.sv
hdl/eth_mac_top.sv
tests/eth_mac_assert.sv
tests/eth_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= eth_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "** PASS **"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/eth_tb.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_tb;
   import eth_reg_pkg::*;

   localparam int MAX_TESTS = 32;

   logic                        clk;
   logic                        rst;
   logic                        sel;
   logic                        we;
   logic [`ETH_REG_ADDR_W-1:0]  addr;
   logic [`ETH_DATA_W-1:0]      data_in;
   logic [`ETH_DATA_W-1:0]      data_out;
   logic                        rx_dv;
   logic [3:0]                  rx_data;
   logic                        tx_en;
   logic [3:0]                  tx_data;
   logic                        interrupt;
   logic                        phy_resetn;

   string       t_name [MAX_TESTS];
   logic [47:0] t_own [MAX_TESTS];
   logic [47:0] t_dest [MAX_TESTS];
   int          t_nbytes [MAX_TESTS];
   int          t_accept [MAX_TESTS];
   int          t_ack [MAX_TESTS];
   int          ntests;

   logic [31:0] lfsr;
   int          check_errors;
   int          other_errors;
   longint      cycles;
   longint      cycle_limit;

   // receive side model
   logic        rx_pending;
   int          last_rx_nbytes;
   logic [7:0]  last_rx_buf [$];

   eth_mac_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .sel        (sel),
      .we         (we),
      .addr       (addr),
      .data_in    (data_in),
      .data_out   (data_out),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .tx_en      (tx_en),
      .tx_data    (tx_data),
      .interrupt  (interrupt),
      .phy_resetn (phy_resetn)
   );

   // mii loopback
   assign rx_dv   = tx_en;
   assign rx_data = tx_data;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("timeout: run exceeded %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
      assert (exp == got) else begin
         $display("CHECK FAILED %s: expected %0h, actual %0h", what, exp, got);
         check_errors++;
      end
   endtask

   task automatic write_reg(input logic [`ETH_REG_ADDR_W-1:0] a, input logic [31:0] d);
      @(posedge clk);
      sel     <= 1'b1;
      we      <= 1'b1;
      addr    <= a;
      data_in <= d;
      @(posedge clk);
      sel <= 1'b0;
      we  <= 1'b0;
   endtask

   // register reads are combinational, window reads need one cycle
   task automatic read_reg(input logic [`ETH_REG_ADDR_W-1:0] a, output logic [31:0] d);
      @(posedge clk);
      addr <= a;
      if (a[`ETH_REG_ADDR_W-1]) begin
         @(posedge clk);
      end
      @(negedge clk);
      d = data_out;
   endtask

   function automatic logic [`ETH_REG_ADDR_W-1:0] reg_addr(input reg_addr_e r);
      return `ETH_REG_ADDR_W'(r);
   endfunction

   function automatic logic [`ETH_REG_ADDR_W-1:0] win_addr(input int i);
      return {1'b1, i[`ETH_BUF_ADDR_W-1:0]};
   endfunction

   task automatic load_stimulus();
      int          fd;
      string       line;
      string       nm;
      logic [47:0] own;
      logic [47:0] dest;
      int          n;
      int          acc;
      int          ack;
      ntests = 0;
      fd = $fopen("tests/eth_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open stimulus file tests/eth_stim.txt");
         other_errors++;
      end else begin
         while (!$feof(fd) && ntests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == 8'h23) begin
               continue;
            end
            if ($sscanf(line, "%s %h %h %d %d %d", nm, own, dest, n, acc, ack) == 6) begin
               t_name[ntests]   = nm;
               t_own[ntests]    = own;
               t_dest[ntests]   = dest;
               t_nbytes[ntests] = n;
               t_accept[ntests] = acc;
               t_ack[ntests]    = ack;
               ntests++;
            end
         end
         $fclose(fd);
      end
   endtask

   // phy reset stays low for 16 full cycles after rst falls
   task automatic check_reset();
      int k;
      for (k = 1; k <= 17; k++) begin
         @(negedge clk);
         check_value($sformatf("reset phy_resetn cycle %0d", k), (k == 17), phy_resetn);
         check_value("reset interrupt", 0, interrupt);
      end
   endtask

   task automatic run_test(input int t);
      logic [7:0]  payload [$];
      logic [3:0]  exp_q [$];
      logic [3:0]  got_q [$];
      logic [7:0]  fb [$];
      logic [7:0]  b;
      logic [31:0] rd;
      string       nm;
      int          n;
      int          i;
      int          k;
      nm = t_name[t];
      n  = t_nbytes[t];
      for (i = 0; i < n; i++) begin
         b = '0;
         for (k = 0; k < 8; k++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
         end
         payload.push_back(b);
      end
      // reference frame, address bytes msb first
      for (i = 0; i < 7; i++) begin
         fb.push_back(8'h55);
      end
      fb.push_back(8'hD5);
      for (i = 5; i >= 0; i--) begin
         fb.push_back(t_dest[t][8*i +: 8]);
      end
      for (i = 5; i >= 0; i--) begin
         fb.push_back(t_own[t][8*i +: 8]);
      end
      foreach (payload[j]) begin
         fb.push_back(payload[j]);
      end
      foreach (fb[j]) begin
         exp_q.push_back(fb[j][3:0]);
         exp_q.push_back(fb[j][7:4]);
      end

      write_reg(reg_addr(MAC_LO), {8'h0, t_own[t][23:0]});
      write_reg(reg_addr(MAC_HI), {8'h0, t_own[t][47:24]});
      write_reg(reg_addr(DEST_LO), {8'h0, t_dest[t][23:0]});
      write_reg(reg_addr(DEST_HI), {8'h0, t_dest[t][47:24]});
      write_reg(reg_addr(TX_NBYTES), 32'(n));
      for (i = 0; i < n; i++) begin
         write_reg(win_addr(i), {24'h0, payload[i]});
      end
      write_reg(reg_addr(CONTROL), 32'h1 << CTRL_SEND);

      @(negedge clk);
      check_value({nm, " tx_en after send"}, 1, tx_en);
      while (tx_en) begin
         got_q.push_back(tx_data);
         @(negedge clk);
      end
      check_value({nm, " tx_en length"}, 32'(2 * (20 + n)), 32'(got_q.size()));
      for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
         check_value($sformatf("%s nibble %0d", nm, i), 32'(exp_q[i]), 32'(got_q[i]));
      end
      read_reg(reg_addr(STATUS), rd);
      check_value({nm, " tx_ready"}, 1, rd[STAT_TX_READY]);
      read_reg(reg_addr(STATUS), rd);

      if (t_accept[t] != 0) begin
         check_value({nm, " rx_ready"}, 1, rd[STAT_RX_READY]);
         rx_pending     = 1'b1;
         last_rx_nbytes = n + 6;
         last_rx_buf    = {};
         // source address and payload follow the destination
         for (i = 14; i < fb.size(); i++) begin
            last_rx_buf.push_back(fb[i]);
         end
      end else begin
         check_value({nm, " rx_ready unchanged"}, 32'(rx_pending), rd[STAT_RX_READY]);
      end
      read_reg(reg_addr(RX_NBYTES), rd);
      check_value({nm, " rx_nbytes"}, 32'(last_rx_nbytes), rd);
      foreach (last_rx_buf[j]) begin
         read_reg(win_addr(j), rd);
         check_value($sformatf("%s rx byte %0d", nm, j), 32'(last_rx_buf[j]), rd);
      end

      // interrupt stays up until both flags are cleared
      check_value({nm, " interrupt after tx"}, 1, interrupt);
      write_reg(reg_addr(INT_EN), 32'h0);
      @(negedge clk);
      check_value({nm, " interrupt masked"}, 0, interrupt);
      write_reg(reg_addr(INT_EN), 32'h1 << INT_EN_BIT);
      @(negedge clk);
      check_value({nm, " interrupt unmasked"}, 1, interrupt);
      write_reg(reg_addr(CONTROL), 32'h1 << CTRL_TX_INT_CLR);
      @(negedge clk);
      check_value({nm, " interrupt after tx clear"}, 32'(rx_pending), interrupt);
      if (t_ack[t] != 0) begin
         write_reg(reg_addr(CONTROL), 32'h1 << CTRL_RX_ACK);
         rx_pending = 1'b0;
         @(negedge clk);
         check_value({nm, " interrupt after rx ack"}, 0, interrupt);
      end
   endtask

   initial begin
      longint budget;
      int     t;
      rst            = 1'b1;
      sel            = 1'b0;
      we             = 1'b0;
      addr           = '0;
      data_in        = '0;
      lfsr           = 32'h3648;
      check_errors   = 0;
      other_errors   = 0;
      cycles         = 0;
      cycle_limit    = 0;
      rx_pending     = 1'b0;
      last_rx_nbytes = 0;

      load_stimulus();
      if (ntests == 0) begin
         $display("stimulus file holds no tests");
         other_errors++;
      end
      budget = 300;
      for (t = 0; t < ntests; t++) begin
         budget += 2 * (20 + t_nbytes[t]) + 10 * (t_nbytes[t] + 6) + 200;
      end
      cycle_limit = budget;

      repeat (3) @(posedge clk);
      rst <= 1'b0;
      check_reset();
      write_reg(reg_addr(INT_EN), 32'h1);
      for (t = 0; t < ntests; t++) begin
         run_test(t);
      end

      $display("errors: %0d check, %0d other", check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/eth_mac_assert.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_mac_assert (
   input wire                        clk,
   input wire                        rst,
   input wire                        sel,
   input wire                        we,
   input wire [`ETH_REG_ADDR_W-1:0]  addr,
   input wire [`ETH_DATA_W-1:0]      data_in,
   input wire                        tx_en,
   input wire [3:0]                  tx_data,
   input wire                        interrupt,
   input wire                        phy_resetn
);
   import eth_reg_pkg::*;

   int unsigned cyc_since_rst;
   logic        int_en_seen;

   // saturating count of cycles out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         cyc_since_rst <= 0;
      end else if (cyc_since_rst < 32) begin
         cyc_since_rst <= cyc_since_rst + 1;
      end
   end

   // enable bit as last written over the register port
   always_ff @(posedge clk) begin
      if (rst) begin
         int_en_seen <= 1'b0;
      end else if (sel && we && addr == `ETH_REG_ADDR_W'(INT_EN)) begin
         int_en_seen <= data_in[INT_EN_BIT];
      end
   end

   a_tx_data_known: assert property (@(posedge clk) disable iff (rst)
      tx_en |-> !$isunknown(tx_data))
      else $error("tx_data unknown while tx_en is high");

   a_int_gated: assert property (@(posedge clk) disable iff (rst)
      !int_en_seen |-> !interrupt)
      else $error("interrupt high while interrupt enable is clear");

   a_phy_reset_hold: assert property (@(posedge clk) disable iff (rst)
      (cyc_since_rst < 16) |-> !phy_resetn)
      else $error("phy_resetn released before 16 cycles");

endmodule

bind eth_mac_top eth_mac_assert u_assert (
   .clk        (clk),
   .rst        (rst),
   .sel        (sel),
   .we         (we),
   .addr       (addr),
   .data_in    (data_in),
   .tx_en      (tx_en),
   .tx_data    (tx_data),
   .interrupt  (interrupt),
   .phy_resetn (phy_resetn)
);

`default_nettype wire

// ==== hdl/eth_mac_top.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_mac_top (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        sel,
   input  wire                        we,
   input  wire [`ETH_REG_ADDR_W-1:0]  addr,
   input  wire [`ETH_DATA_W-1:0]      data_in,
   output logic [`ETH_DATA_W-1:0]     data_out,
   input  wire                        rx_dv,
   input  wire [3:0]                  rx_data,
   output logic                       tx_en,
   output logic [3:0]                 tx_data,
   output logic                       interrupt,
   output logic                       phy_resetn
);
   import eth_frame_pkg::*;

   mac_addr_t                    mac_addr;
   mac_addr_t                    dest_mac_addr;
   logic                         tx_buf_we;
   byte_t                        rx_buf_rd_data;
   logic                         tx_send;
   logic [`ETH_NBYTES_W-1:0]     tx_nbytes;
   logic                         tx_busy;
   logic                         tx_done;
   logic [`ETH_BUF_ADDR_W-1:0]   tx_rd_addr;
   byte_t                        tx_rd_data;
   logic                         rx_ready;
   logic                         rx_done;
   logic [`ETH_NBYTES_W-1:0]     rx_nbytes;
   logic                         rx_wr;
   logic [`ETH_BUF_ADDR_W-1:0]   rx_wr_addr;
   byte_t                        rx_wr_data;

   eth_regs u_regs (
      .clk            (clk),
      .rst            (rst),
      .sel            (sel),
      .we             (we),
      .addr           (addr),
      .data_in        (data_in),
      .data_out       (data_out),
      .tx_buf_we      (tx_buf_we),
      .rx_buf_rd_data (rx_buf_rd_data),
      .tx_busy        (tx_busy),
      .tx_done        (tx_done),
      .rx_done        (rx_done),
      .rx_nbytes      (rx_nbytes),
      .tx_send        (tx_send),
      .tx_nbytes      (tx_nbytes),
      .mac_addr       (mac_addr),
      .dest_mac_addr  (dest_mac_addr),
      .rx_ready       (rx_ready),
      .interrupt      (interrupt),
      .phy_resetn     (phy_resetn)
   );

   // software fills the tx buffer through the window
   eth_buffer u_tx_buf (
      .clk     (clk),
      .we      (tx_buf_we),
      .wr_addr (addr[`ETH_BUF_ADDR_W-1:0]),
      .wr_data (data_in[7:0]),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data)
   );

   eth_buffer u_rx_buf (
      .clk     (clk),
      .we      (rx_wr),
      .wr_addr (rx_wr_addr),
      .wr_data (rx_wr_data),
      .rd_addr (addr[`ETH_BUF_ADDR_W-1:0]),
      .rd_data (rx_buf_rd_data)
   );

   eth_tx u_tx (
      .clk           (clk),
      .rst           (rst),
      .send          (tx_send),
      .nbytes        (tx_nbytes),
      .mac_addr      (mac_addr),
      .dest_mac_addr (dest_mac_addr),
      .rd_data       (tx_rd_data),
      .rd_addr       (tx_rd_addr),
      .tx_en         (tx_en),
      .tx_data       (tx_data),
      .busy          (tx_busy),
      .done          (tx_done)
   );

   // a pending rx frame blocks the receiver
   eth_rx u_rx (
      .clk      (clk),
      .rst      (rst),
      .rx_dv    (rx_dv),
      .rx_data  (rx_data),
      .mac_addr (mac_addr),
      .hold     (rx_ready),
      .wr       (rx_wr),
      .wr_addr  (rx_wr_addr),
      .wr_data  (rx_wr_data),
      .done     (rx_done),
      .nbytes   (rx_nbytes)
   );

endmodule

`default_nettype wire

// ==== eth_rx/eth_rx.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_rx (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          rx_dv,
   input  wire [3:0]                    rx_data,
   input  wire eth_frame_pkg::mac_addr_t mac_addr,
   input  wire                          hold,
   output logic                         wr,
   output logic [`ETH_BUF_ADDR_W-1:0]   wr_addr,
   output eth_frame_pkg::byte_t         wr_data,
   output logic                         done,
   output logic [`ETH_NBYTES_W-1:0]     nbytes
);
   import eth_frame_pkg::*;

   localparam int NB_W  = `ETH_NBYTES_W;
   localparam int DEPTH = `ETH_BUF_DEPTH;

   typedef enum logic [1:0] {R_HUNT, R_DST, R_DATA, R_DROP} state_t;

   state_t          state;
   nibble_t         lo_nib;
   logic            nib_hi;
   logic [2:0]      dst_cnt;
   logic [NB_W-1:0] count;
   byte_t           cur_byte;
   byte_t           exp_byte;

   // low nibble arrives first
   assign cur_byte = {rx_data, lo_nib};
   assign exp_byte = mac_addr[8 * (MAC_BYTES - 1 - int'(dst_cnt)) +: 8];

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= R_HUNT;
         lo_nib  <= '0;
         nib_hi  <= 1'b0;
         dst_cnt <= '0;
         count   <= '0;
         wr      <= 1'b0;
         done    <= 1'b0;
         nbytes  <= '0;
      end else begin
         wr   <= 1'b0;
         done <= 1'b0;
         if (!rx_dv) begin
            // end of frame
            if (state == R_DATA) begin
               done   <= 1'b1;
               nbytes <= count;
            end
            state  <= R_HUNT;
            nib_hi <= 1'b0;
            lo_nib <= '0;
         end else begin
            // hunting slides one nibble at a time
            if (state == R_HUNT || !nib_hi) begin
               lo_nib <= rx_data;
            end
            if (state != R_HUNT) begin
               nib_hi <= ~nib_hi;
            end
            case (state)
               R_HUNT: begin
                  if (hold) begin
                     state <= R_DROP;
                  end else if (cur_byte == SFD_BYTE) begin
                     state   <= R_DST;
                     dst_cnt <= '0;
                  end
               end
               R_DST: begin
                  if (nib_hi) begin
                     if (cur_byte != exp_byte) begin
                        state <= R_DROP;
                     end else if (dst_cnt == 3'(MAC_BYTES - 1)) begin
                        state <= R_DATA;
                        count <= '0;
                     end else begin
                        dst_cnt <= dst_cnt + 3'd1;
                     end
                  end
               end
               R_DATA: begin
                  // bytes past the buffer end are not stored
                  if (nib_hi && count < NB_W'(DEPTH)) begin
                     wr      <= 1'b1;
                     wr_addr <= count[`ETH_BUF_ADDR_W-1:0];
                     wr_data <= cur_byte;
                     count   <= count + 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== eth_tx/eth_tx.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_tx (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          send,
   input  wire [`ETH_NBYTES_W-1:0]      nbytes,
   input  wire eth_frame_pkg::mac_addr_t mac_addr,
   input  wire eth_frame_pkg::mac_addr_t dest_mac_addr,
   input  wire eth_frame_pkg::byte_t    rd_data,
   output logic [`ETH_BUF_ADDR_W-1:0]   rd_addr,
   output logic                         tx_en,
   output logic [3:0]                   tx_data,
   output logic                         busy,
   output logic                         done
);
   import eth_frame_pkg::*;

   localparam int NB_W = `ETH_NBYTES_W;

   // state names the byte that is loaded next
   typedef enum logic [2:0] {
      S_IDLE, S_PRE, S_SFD, S_DST, S_SRC, S_DATA, S_LAST
   } state_t;

   state_t          state;
   logic [2:0]      cnt;
   logic [NB_W-1:0] data_cnt;
   logic            pend_hi;
   nibble_t         hi_nib;
   byte_t           next_byte;

   always_comb begin
      case (state)
         S_PRE:   next_byte = PREAMBLE_BYTE;
         S_SFD:   next_byte = SFD_BYTE;
         S_DST:   next_byte = dest_mac_addr[8 * (MAC_BYTES - 1 - int'(cnt)) +: 8];
         S_SRC:   next_byte = mac_addr[8 * (MAC_BYTES - 1 - int'(cnt)) +: 8];
         S_DATA:  next_byte = rd_data;
         default: next_byte = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= S_IDLE;
         cnt      <= '0;
         data_cnt <= '0;
         pend_hi  <= 1'b0;
         tx_en    <= 1'b0;
         tx_data  <= '0;
      end else if (!tx_en) begin
         if (send) begin
            tx_en    <= 1'b1;
            tx_data  <= PREAMBLE_BYTE[3:0];
            hi_nib   <= PREAMBLE_BYTE[7:4];
            pend_hi  <= 1'b1;
            state    <= S_PRE;
            cnt      <= 3'd1;
            data_cnt <= '0;
         end
      end else if (pend_hi) begin
         tx_data <= hi_nib;
         pend_hi <= 1'b0;
      end else if (state == S_LAST) begin
         tx_en   <= 1'b0;
         tx_data <= '0;
         state   <= S_IDLE;
      end else begin
         tx_data <= next_byte[3:0];
         hi_nib  <= next_byte[7:4];
         pend_hi <= 1'b1;
         cnt     <= cnt + 3'd1;
         case (state)
            S_PRE: begin
               if (cnt == 3'(PREAMBLE_LEN - 1)) begin
                  state <= S_SFD;
               end
            end
            S_SFD: begin
               state <= S_DST;
               cnt   <= '0;
            end
            S_DST: begin
               if (cnt == 3'(MAC_BYTES - 1)) begin
                  state <= S_SRC;
                  cnt   <= '0;
               end
            end
            S_SRC: begin
               if (cnt == 3'(MAC_BYTES - 1)) begin
                  state <= (nbytes == '0) ? S_LAST : S_DATA;
               end
            end
            default: begin
               // payload, next address is already on the RAM
               data_cnt <= data_cnt + 1'b1;
               if (data_cnt + 1'b1 == nbytes) begin
                  state <= S_LAST;
               end
            end
         endcase
      end
   end

   assign rd_addr = data_cnt[`ETH_BUF_ADDR_W-1:0];
   assign busy    = tx_en;
   assign done    = tx_en & ~pend_hi & (state == S_LAST);

endmodule

`default_nettype wire

// ==== hdl/eth_regs.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_regs (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          sel,
   input  wire                          we,
   input  wire [`ETH_REG_ADDR_W-1:0]    addr,
   input  wire [`ETH_DATA_W-1:0]        data_in,
   output logic [`ETH_DATA_W-1:0]       data_out,
   output logic                         tx_buf_we,
   input  wire eth_frame_pkg::byte_t    rx_buf_rd_data,
   input  wire                          tx_busy,
   input  wire                          tx_done,
   input  wire                          rx_done,
   input  wire [`ETH_NBYTES_W-1:0]      rx_nbytes,
   output logic                         tx_send,
   output logic [`ETH_NBYTES_W-1:0]     tx_nbytes,
   output eth_frame_pkg::mac_addr_t     mac_addr,
   output eth_frame_pkg::mac_addr_t     dest_mac_addr,
   output logic                         rx_ready,
   output logic                         interrupt,
   output logic                         phy_resetn
);
   import eth_reg_pkg::*;

   localparam int DATA_W    = `ETH_DATA_W;
   localparam int BUF_W     = `ETH_BUF_ADDR_W;
   localparam int NB_W      = `ETH_NBYTES_W;
   localparam int RST_CNT_W = $clog2(`ETH_PHY_RST_CYCLES);

   logic                 win;
   logic [BUF_W-1:0]     idx;
   logic                 reg_wr;
   logic                 ctrl_wr;
   logic                 int_en;
   logic                 tx_int;
   logic [RST_CNT_W-1:0] rst_cnt;

   assign win     = addr[`ETH_REG_ADDR_W-1];
   assign idx     = addr[BUF_W-1:0];
   assign reg_wr  = sel & we & ~win;
   assign ctrl_wr = reg_wr && (idx == BUF_W'(CONTROL));

   assign tx_buf_we = sel & we & win;
   assign tx_send   = ctrl_wr & data_in[CTRL_SEND] & ~tx_busy;

   // configuration registers
   always_ff @(posedge clk) begin
      if (reg_wr) begin
         case (idx)
            BUF_W'(TX_NBYTES): tx_nbytes <= data_in[NB_W-1:0];
            BUF_W'(MAC_LO):    mac_addr[MAC_REG_W-1:0] <= data_in[MAC_REG_W-1:0];
            BUF_W'(MAC_HI):    mac_addr[2*MAC_REG_W-1:MAC_REG_W] <= data_in[MAC_REG_W-1:0];
            BUF_W'(DEST_LO):   dest_mac_addr[MAC_REG_W-1:0] <= data_in[MAC_REG_W-1:0];
            BUF_W'(DEST_HI):
               dest_mac_addr[2*MAC_REG_W-1:MAC_REG_W] <= data_in[MAC_REG_W-1:0];
            default: ;
         endcase
      end
   end

   // rx_ready doubles as the rx interrupt flag
   always_ff @(posedge clk) begin
      if (rst) begin
         int_en   <= 1'b0;
         tx_int   <= 1'b0;
         rx_ready <= 1'b0;
      end else begin
         if (reg_wr && (idx == BUF_W'(INT_EN))) begin
            int_en <= data_in[INT_EN_BIT];
         end
         if (tx_done) begin
            tx_int <= 1'b1;
         end else if (ctrl_wr && data_in[CTRL_TX_INT_CLR]) begin
            tx_int <= 1'b0;
         end
         if (rx_done) begin
            rx_ready <= 1'b1;
         end else if (ctrl_wr && data_in[CTRL_RX_ACK]) begin
            rx_ready <= 1'b0;
         end
      end
   end

   assign interrupt = int_en & (tx_int | rx_ready);

   always_comb begin
      data_out = '0;
      if (win) begin
         data_out = DATA_W'(rx_buf_rd_data);
      end else begin
         case (idx)
            BUF_W'(STATUS): begin
               data_out[STAT_TX_READY] = ~tx_busy;
               data_out[STAT_RX_READY] = rx_ready;
            end
            BUF_W'(TX_NBYTES): data_out = DATA_W'(tx_nbytes);
            BUF_W'(RX_NBYTES): data_out = DATA_W'(rx_nbytes);
            BUF_W'(INT_EN):    data_out = DATA_W'(int_en);
            BUF_W'(MAC_LO):    data_out = DATA_W'(mac_addr[MAC_REG_W-1:0]);
            BUF_W'(MAC_HI):    data_out = DATA_W'(mac_addr[2*MAC_REG_W-1:MAC_REG_W]);
            BUF_W'(DEST_LO):   data_out = DATA_W'(dest_mac_addr[MAC_REG_W-1:0]);
            BUF_W'(DEST_HI):   data_out = DATA_W'(dest_mac_addr[2*MAC_REG_W-1:MAC_REG_W]);
            default: ;
         endcase
      end
   end

   // phy held in reset for a fixed count after rst
   always_ff @(posedge clk) begin
      if (rst) begin
         rst_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else begin
         if (rst_cnt != RST_CNT_W'(`ETH_PHY_RST_CYCLES - 1)) begin
            rst_cnt <= rst_cnt + 1'b1;
         end
         phy_resetn <= (rst_cnt == RST_CNT_W'(`ETH_PHY_RST_CYCLES - 1));
      end
   end

endmodule

`default_nettype wire

// ==== hdl/eth_buffer.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_buffer (
   input  wire                         clk,
   input  wire                         we,
   input  wire [`ETH_BUF_ADDR_W-1:0]   wr_addr,
   input  wire eth_frame_pkg::byte_t   wr_data,
   input  wire [`ETH_BUF_ADDR_W-1:0]   rd_addr,
   output eth_frame_pkg::byte_t        rd_data
);
   import eth_frame_pkg::*;

   localparam int DEPTH = `ETH_BUF_DEPTH;

   byte_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, one cycle latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== common/eth_frame_pkg.sv ====
`default_nettype none

package eth_frame_pkg;

   typedef logic [47:0] mac_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;

   // framing bytes
   localparam byte_t PREAMBLE_BYTE = 8'h55;
   localparam byte_t SFD_BYTE      = 8'hD5;
   localparam int    PREAMBLE_LEN  = 7;

   // destination plus source address
   localparam int HDR_BYTES = 12;
   localparam int MAC_BYTES = HDR_BYTES / 2;

endpackage

`default_nettype wire

// ==== common/eth_reg_pkg.sv ====
`default_nettype none

package eth_reg_pkg;

   // register index within the register window
   typedef enum logic [3:0] {
      STATUS    = 4'd0,
      CONTROL   = 4'd1,
      TX_NBYTES = 4'd2,
      RX_NBYTES = 4'd3,
      INT_EN    = 4'd4,
      MAC_LO    = 4'd5,
      MAC_HI    = 4'd6,
      DEST_LO   = 4'd7,
      DEST_HI   = 4'd8
   } reg_addr_e;

   // control write bits
   localparam int CTRL_SEND       = 0;
   localparam int CTRL_RX_ACK     = 1;
   localparam int CTRL_TX_INT_CLR = 2;

   // status read bits
   localparam int STAT_TX_READY = 0;
   localparam int STAT_RX_READY = 1;

   localparam int INT_EN_BIT = 0;

   // each mac register carries half an address
   localparam int MAC_REG_W = 24;

endpackage

`default_nettype wire

// ==== common/eth_params.svh ====
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

// register bus width
`define ETH_DATA_W 32

// byte address of each frame buffer
`define ETH_BUF_ADDR_W 7
`define ETH_BUF_DEPTH (1 << `ETH_BUF_ADDR_W)

// byte counts must reach the full depth
`define ETH_NBYTES_W (`ETH_BUF_ADDR_W + 1)

// top bit selects the buffer window
`define ETH_REG_ADDR_W (`ETH_BUF_ADDR_W + 1)

// phy reset hold time in clk cycles
`define ETH_PHY_RST_CYCLES 16

`endif
